/* imuldiv_top.f */
design/imuldiv_pkg.sv
design/div_ctrl_if.sv
design/div_dpath.sv
design/div_ctrl.sv
design/mul_iterative.sv
design/imuldiv_top.sv
tb/imuldiv_tb.sv

/* Makefile */
# Verilator build and run for the multiply/divide unit

TOP := imuldiv_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --top-module $(TOP) -f imuldiv_top.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tb/imuldiv_tb.sv */
//------------------------------
// multiply/divide unit testbench
// val/rdy stimulus, reference model, in-order checks
//------------------------------

`timescale 1ns/1ps

module imuldiv_tb import imuldiv_pkg::*; ();

  logic                clk;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  imuldiv_fn_e         req_fn;
  logic [data_w-1:0]   req_a;
  logic [data_w-1:0]   req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [result_w-1:0] resp_result;

  // request list built before reset is released
  imuldiv_fn_e       fn_q[$];
  logic [data_w-1:0] a_q[$];
  logic [data_w-1:0] b_q[$];
  // expected results in request order
  logic [result_w-1:0] exp_q[$];

  integer seed;
  int errors = 0;
  int checks = 0;
  int n_req = 0;
  int resp_count = 0;
  int cycle = 0;
  int cycle_limit = 0;
  int acc_cycle = 0;
  logic val_seen = 1'b0;
  logic hold_valid = 1'b0;
  logic [result_w-1:0] held_result = '0;

  imuldiv_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  //------------------------------
  // reference model
  //------------------------------

  // {remainder, quotient} for divides or the full product for multiplies
  function automatic logic [result_w-1:0] ref_result(imuldiv_fn_e fn,
                                                     logic [data_w-1:0] a,
                                                     logic [data_w-1:0] b);
    longint sa;
    longint sb;
    longint unsigned ua;
    longint unsigned ub;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'd0, a};
    ub = {32'd0, b};
    case (fn)
      fn_mul:  return sa * sb;
      fn_mulu: return ua * ub;
      fn_divu: begin
        if (b == '0) return {a, 32'hffff_ffff};
        return {32'(ua % ub), 32'(ua / ub)};
      end
      default: begin
        if (b == '0) return {a, 32'hffff_ffff};
        // min / -1 gives 2^31 in 64 bits and truncates back to the dividend
        return {32'(sa % sb), 32'(sa / sb)};
      end
    endcase
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_req(imuldiv_fn_e fn, logic [data_w-1:0] a, logic [data_w-1:0] b);
    fn_q.push_back(fn);
    a_q.push_back(a);
    b_q.push_back(b);
  endtask

  task automatic finish_run();
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: %0d accepted requests never got a response", exp_q.size());
    end
    $display("checks %0d, errors %0d, responses %0d of %0d", checks, errors, resp_count, n_req);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  //------------------------------
  // stimulus
  //------------------------------

  // hold val and data until the request transfers
  task automatic drive_requests();
    for (int i = 0; i < n_req; i++) begin
      req_val = 1'b1;
      req_fn  = fn_q[i];
      req_a   = a_q[i];
      req_b   = b_q[i];
      do @(posedge clk); while (!req_rdy);
      #1;
    end
    req_val = 1'b0;
  endtask

  // random low and high stretches of resp_rdy
  task automatic apply_backpressure();
    int low_n;
    int high_n;
    forever begin
      low_n  = $unsigned($random(seed)) % 4;
      high_n = 1 + $unsigned($random(seed)) % 4;
      if (low_n > 0) begin
        resp_rdy = 1'b0;
        repeat (low_n) begin
          @(posedge clk);
          #1;
        end
      end
      resp_rdy = 1'b1;
      repeat (high_n) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin
    int sel;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    seed     = 32'h985c_decd;
    // unsigned divide including divide by zero
    add_req(fn_divu, 32'd100, 32'd7);
    add_req(fn_divu, 32'hffff_ffff, 32'd1);
    add_req(fn_divu, 32'hffff_ffff, 32'hffff_ffff);
    add_req(fn_divu, 32'h8000_0000, 32'd3);
    add_req(fn_divu, 32'd5, 32'd0);
    add_req(fn_divu, 32'd0, 32'd9);
    // every sign combination of signed divide
    add_req(fn_div, 32'd7, 32'd2);
    add_req(fn_div, -32'd7, 32'd2);
    add_req(fn_div, 32'd7, -32'd2);
    add_req(fn_div, -32'd7, -32'd2);
    add_req(fn_div, 32'h8000_0000, 32'hffff_ffff);
    add_req(fn_div, 32'h8000_0000, 32'd1);
    add_req(fn_div, -32'd5, 32'd0);
    add_req(fn_div, 32'd5, 32'd0);
    // extreme multiply operands
    add_req(fn_mul, 32'd3, -32'd4);
    add_req(fn_mul, 32'h8000_0000, 32'h8000_0000);
    add_req(fn_mul, 32'h7fff_ffff, 32'h7fff_ffff);
    add_req(fn_mul, 32'h8000_0000, 32'h7fff_ffff);
    add_req(fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    add_req(fn_mulu, 32'hffff_ffff, 32'hffff_ffff);
    add_req(fn_mulu, 32'h8000_0000, 32'd2);
    add_req(fn_mulu, 32'd12345, 32'd6789);
    // random mix with some zero and small divisors
    repeat (48) begin
      a   = $random(seed);
      b   = $random(seed);
      sel = $unsigned($random(seed)) % 8;
      if (sel == 0) b = '0;
      if (sel == 1) b = b & 32'h0000_00ff;
      if (sel == 2) a = 32'h8000_0000;
      add_req(imuldiv_fn_e'(2'($unsigned($random(seed)))), a, b);
    end
    n_req       = fn_q.size();
    cycle_limit = 40 * n_req + 200;
    // two reset cycles
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("req_rdy", 64'(req_rdy), 64'd1);
    check_value("resp_val", 64'(resp_val), 64'd0);
    fork
      drive_requests();
      apply_backpressure();
    join_none
    wait (resp_count == n_req);
    // let the monitor finish its last edge before the summary
    @(posedge clk);
    #1;
    finish_run();
  end

  //------------------------------
  // response monitor
  //------------------------------

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!reset) begin
      if (req_val && req_rdy) begin
        exp_q.push_back(ref_result(req_fn, req_a, req_b));
        acc_cycle = cycle;
      end
      if (resp_val) begin
        // no new request while a response is pending
        check_value("req_rdy", 64'(req_rdy), 64'd0);
        if (!val_seen) begin
          // rising edge is one edge before this sample
          check_value("resp_latency", 64'(cycle - acc_cycle - 1), 64'(iter_n + 1));
          val_seen = 1'b1;
        end
        if (hold_valid) begin
          check_value("resp_result", resp_result, held_result);
        end
        if (resp_rdy) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR: response transferred with no request outstanding");
          end else begin
            check_value("resp_result", resp_result, exp_q.pop_front());
          end
          resp_count++;
          val_seen   = 1'b0;
          hold_valid = 1'b0;
        end else begin
          hold_valid  = 1'b1;
          held_result = resp_result;
        end
      end
    end
    if (cycle >= cycle_limit) begin
      errors++;
      $display("ERROR: timeout after %0d cycles, %0d of %0d responses seen",
               cycle, resp_count, n_req);
      finish_run();
    end
  end

endmodule

/* design/imuldiv_top.sv */
//------------------------------
// integer multiply/divide unit
// one val/rdy request port, one response port
//------------------------------

`timescale 1ns/1ps

module imuldiv_top import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  imuldiv_fn_e         req_fn,
  input  logic [data_w-1:0]   req_a,
  input  logic [data_w-1:0]   req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [result_w-1:0] resp_result
);

  //------------------------------
  // request dispatch
  //------------------------------

  logic is_div;
  logic div_req_val;
  logic mul_req_val;

  logic div_idle_w;
  logic div_done_w;
  logic mul_idle_w;
  logic mul_done_w;

  logic [result_w-1:0] div_result;
  logic [result_w-1:0] mul_result;

  assign is_div = (req_fn == fn_div) || (req_fn == fn_divu);

  // one operation in flight, so responses stay in order
  assign req_rdy = div_idle_w && mul_idle_w;

  // an engine only sees a request that the port actually accepts
  assign div_req_val = req_val && req_rdy && is_div;
  assign mul_req_val = req_val && req_rdy && !is_div;

  //------------------------------
  // divider
  //------------------------------

  div_ctrl_if div_if (.clk(clk));

  div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_fn   (req_fn),
    .resp_rdy (resp_rdy),
    .idle     (div_idle_w),
    .done     (div_done_w),
    .ctrl     (div_if.ctrl)
  );

  div_dpath u_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .req_a  (req_a),
    .req_b  (req_b),
    .dpath  (div_if.dpath),
    .result (div_result)
  );

  //------------------------------
  // multiplier
  //------------------------------

  mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .resp_rdy (resp_rdy),
    .idle     (mul_idle_w),
    .done     (mul_done_w),
    .result   (mul_result)
  );

  //------------------------------
  // response select
  //------------------------------

  // at most one engine is done at a time
  assign resp_val    = div_done_w || mul_done_w;
  assign resp_result = div_done_w ? div_result : mul_result;

endmodule

/* design/mul_iterative.sv */
//------------------------------
// iterative shift-add multiplier
// 32 add/shift steps, then sign fixup
//------------------------------

`timescale 1ns/1ps

module mul_iterative import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  input  imuldiv_fn_e         req_fn,
  input  logic [data_w-1:0]   req_a,
  input  logic [data_w-1:0]   req_b,
  input  logic                resp_rdy,
  output logic                idle,
  output logic                done,
  output logic [result_w-1:0] result
);

  //------------------------------
  // control
  //------------------------------

  mul_state_e         state_q;
  logic [count_w-1:0] count_q;
  // last add/shift already issued
  logic               last_q;

  logic accept;
  logic respond;
  logic step;

  assign idle    = (state_q == mul_idle);
  assign done    = (state_q == mul_done);
  assign accept  = req_val && idle;
  assign respond = resp_rdy && done;
  assign step    = (state_q == mul_calc) && !last_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= mul_idle;
      count_q <= '0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        mul_idle: begin
          if (accept) begin
            state_q <= mul_calc;
            count_q <= '0;
            last_q  <= 1'b0;
          end
        end
        mul_calc: begin
          if (!last_q) begin
            count_q <= count_q + 1'b1;
            if (count_q == count_w'(iter_n - 1)) begin
              last_q <= 1'b1;
            end
          end else begin
            last_q  <= 1'b0;
            state_q <= mul_done;
          end
        end
        mul_done: begin
          if (respond) begin
            state_q <= mul_idle;
          end
        end
        default: state_q <= mul_idle;
      endcase
    end
  end

  //------------------------------
  // datapath
  //------------------------------

  logic                is_signed;
  logic [data_w-1:0]   a_mag;
  logic [data_w-1:0]   b_mag;
  // multiplicand moves left, multiplier moves right
  logic [result_w-1:0] mcand_q;
  logic [data_w-1:0]   mplier_q;
  logic [result_w-1:0] acc_q;
  logic                prod_neg_q;

  assign is_signed = (req_fn == fn_mul);
  assign a_mag = (is_signed && req_a[data_w-1]) ? -req_a : req_a;
  assign b_mag = (is_signed && req_b[data_w-1]) ? -req_b : req_b;

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand_q    <= {{data_w{1'b0}}, a_mag};
      mplier_q   <= b_mag;
      acc_q      <= '0;
      prod_neg_q <= is_signed && (req_a[data_w-1] ^ req_b[data_w-1]);
    end else if (step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // magnitude product back to two's complement
  assign result = prod_neg_q ? -acc_q : acc_q;

endmodule

/* design/div_ctrl.sv */
//------------------------------
// divider control FSM
// sequences load and the 32 steps, owns val/rdy
//------------------------------

`timescale 1ns/1ps

module div_ctrl import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  input  imuldiv_fn_e req_fn,
  input  logic        resp_rdy,
  output logic        idle,
  output logic        done,
  div_ctrl_if.ctrl    ctrl
);

  div_state_e         state_q;
  logic [count_w-1:0] count_q;
  // set once the last step has been issued
  logic               last_q;
  // signedness of the operation in flight
  logic               signed_q;

  logic accept;
  logic respond;

  assign idle = (state_q == div_idle);
  assign done = (state_q == div_done);

  // request and response transfers
  assign accept  = req_val && idle;
  assign respond = resp_rdy && done;

  //------------------------------
  // state, counter, signedness
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= div_idle;
      count_q  <= '0;
      last_q   <= 1'b0;
      signed_q <= 1'b0;
    end else begin
      case (state_q)
        div_idle: begin
          if (accept) begin
            state_q  <= div_calc;
            count_q  <= '0;
            last_q   <= 1'b0;
            signed_q <= (req_fn == fn_div);
          end
        end
        div_calc: begin
          if (!last_q) begin
            // counter wraps back to zero after the 32nd step
            count_q <= count_q + 1'b1;
            if (count_q == count_w'(iter_n - 1)) begin
              last_q <= 1'b1;
            end
          end else begin
            // one cycle after the final step, result is settled
            last_q  <= 1'b0;
            state_q <= div_done;
          end
        end
        div_done: begin
          // hold the result until the consumer takes it
          if (respond) begin
            state_q <= div_idle;
          end
        end
        default: state_q <= div_idle;
      endcase
    end
  end

  //------------------------------
  // datapath controls
  //------------------------------

  assign ctrl.load = accept;
  assign ctrl.step = (state_q == div_calc) && !last_q;

  // straight from the request while idle so load sees it on the accept edge
  assign ctrl.signed_op = idle ? (req_fn == fn_div) : signed_q;

endmodule

/* design/div_dpath.sv */
//------------------------------
// divider datapath
// restoring shift-subtract with sign fixup
//------------------------------

`timescale 1ns/1ps

module div_dpath import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [data_w-1:0]   req_a,
  input  logic [data_w-1:0]   req_b,
  div_ctrl_if.dpath           dpath,
  output logic [result_w-1:0] result
);

  //------------------------------
  // operand conditioning
  //------------------------------

  // magnitudes for signed divide, raw bits otherwise
  logic [data_w-1:0] a_mag;
  logic [data_w-1:0] b_mag;

  assign a_mag = (dpath.signed_op && req_a[data_w-1]) ? -req_a : req_a;
  assign b_mag = (dpath.signed_op && req_b[data_w-1]) ? -req_b : req_b;

  // operand signs and divide-by-zero flag, held for the final fixup
  logic a_sign_q;
  logic b_sign_q;
  logic b_zero_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_sign_q <= 1'b0;
      b_sign_q <= 1'b0;
      b_zero_q <= 1'b0;
    end else if (dpath.load) begin
      a_sign_q <= req_a[data_w-1];
      b_sign_q <= req_b[data_w-1];
      b_zero_q <= (req_b == '0);
    end
  end

  //------------------------------
  // shift-subtract iteration
  //------------------------------

  // rq_q is {borrow, remainder, quotient}, 65 bits wide
  // the dividend starts in the low word and walks up one bit per step
  logic [result_w:0] rq_q;
  // divisor aligned with the remainder field
  logic [result_w:0] div_q;

  logic [result_w:0] rq_shift;
  logic [result_w:0] rq_diff;
  logic [result_w:0] rq_next;

  assign rq_shift = rq_q << 1;
  assign rq_diff  = rq_shift - div_q;

  // top bit set means the divisor did not fit
  assign dpath.sub_neg = rq_diff[result_w];

  // fit: keep difference, quotient bit 1
  // no fit: restore shifted value, quotient bit 0
  assign rq_next = dpath.sub_neg ? {rq_shift[result_w:1], 1'b0}
                                 : {rq_diff[result_w:1], 1'b1};

  always_ff @(posedge clk) begin
    if (dpath.load) begin
      rq_q  <= {{(data_w + 1){1'b0}}, a_mag};
      div_q <= {1'b0, b_mag, {data_w{1'b0}}};
    end else if (dpath.step) begin
      rq_q <= rq_next;
    end
  end

  //------------------------------
  // sign correction
  //------------------------------

  logic [data_w-1:0] quot_mag;
  logic [data_w-1:0] rem_mag;
  logic [data_w-1:0] quot;
  logic [data_w-1:0] rem;
  logic              quot_neg;
  logic              rem_neg;

  // after iter_n steps the remainder sits right above the quotient
  assign quot_mag = rq_q[data_w-1:0];
  assign rem_mag  = rq_q[result_w-1:data_w];

  // divide by zero keeps the all-ones quotient unsigned-looking (= -1)
  assign quot_neg = dpath.signed_op && (a_sign_q ^ b_sign_q) && !b_zero_q;
  // remainder follows the dividend sign
  assign rem_neg  = dpath.signed_op && a_sign_q;

  assign quot = quot_neg ? -quot_mag : quot_mag;
  assign rem  = rem_neg  ? -rem_mag  : rem_mag;

  // remainder high, quotient low
  assign result = {rem, quot};

endmodule

/* design/div_ctrl_if.sv */
//------------------------------
// divider control/status bundle
// between the divider FSM and its datapath
//------------------------------

`timescale 1ns/1ps

interface div_ctrl_if (
  input logic clk
);

  // capture operands, signs and zero flag
  logic load;
  // one shift-subtract iteration
  logic step;
  // signed divide, valid during load and while busy
  logic signed_op;
  // borrow out of the trial subtraction
  logic sub_neg;

  modport ctrl (
    input  clk,
    input  sub_neg,
    output load,
    output step,
    output signed_op
  );

  modport dpath (
    input  clk,
    input  load,
    input  step,
    input  signed_op,
    output sub_neg
  );

endinterface

/* design/imuldiv_pkg.sv */
//------------------------------
// multiply/divide unit package
// function codes, FSM states and widths
//------------------------------

package imuldiv_pkg;

  //------------------------------
  // widths
  //------------------------------

  // operand width of the processor
  localparam int data_w = 32;

  // full product or {remainder, quotient}
  localparam int result_w = 64;

  // one iteration per operand bit
  localparam int iter_n = 32;

  // holds 0 .. iter_n-1
  localparam int count_w = 5;

  //------------------------------
  // function codes
  //------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_e;

  //------------------------------
  // engine states
  //------------------------------

  typedef enum logic [1:0] {
    div_idle = 2'd0,
    div_calc = 2'd1,
    div_done = 2'd2
  } div_state_e;

  typedef enum logic [1:0] {
    mul_idle = 2'd0,
    mul_calc = 2'd1,
    mul_done = 2'd2
  } mul_state_e;

endpackage
